// ==== src/ffu_pkg.sv ====
package ffu_pkg;

   ////////////////////
   // sizes
   ////////////////////
   localparam int num_threads = 4;
   localparam int data_w      = 64;
   localparam int half_w      = data_w / 2;  // one single-precision word

   // where the fsr fields sit in the 64-bit store image
   // fcc0, aexc and cexc always occupy bits 11:0
   localparam int fsr_st_fcc_hi_lsb = 32;
   localparam int fsr_st_rnd_lsb    = 30;
   localparam int fsr_st_tem_lsb    = 23;
   localparam int fsr_st_ftt_lsb    = 14;

   typedef logic [data_w-1:0]      data_t;
   typedef logic [num_threads-1:0] thread_sel_t;  // bit n is thread n

   ////////////////////
   // state registers
   ////////////////////
   // only the 28 live fsr bits are stored, the rest read as zero
   typedef struct packed {
      logic [5:0] fcc_hi;  // fcc3..fcc1
      logic [1:0] rnd;
      logic [4:0] tem;
      logic [2:0] ftt;
      logic [1:0] fcc0;
      logic [4:0] aexc;
      logic [4:0] cexc;
   } fsr_t;

   typedef struct packed {
      logic [7:0] fcc;     // fcc3..fcc1 then fcc0
      logic [1:0] rnd;
      logic [4:0] tem;
      logic [4:0] aexc;
      logic [4:0] cexc;
   } fsr_view_t;

   typedef struct packed {
      logic [31:0] mask;
      logic [4:0]  scale;
   } gsr_t;

   typedef struct packed {
      thread_sel_t ld_wr;   // ldfsr / ldxfsr completion
      thread_sel_t fpu_wr;  // fpu op completion
      logic [7:0]  fcc;
      logic [9:0]  exc;     // aexc then cexc
      logic [2:0]  ftt;
   } fsr_upd_t;

   ////////////////////
   // one-hot selects
   ////////////////////
   typedef struct packed {
      logic none;
      logic right;  // upper word down to the low half
      logic left;   // lower word up to the high half
   } frf_shift_t;

   typedef struct packed {
      logic lsu;
      logic lsu_swap;
      logic fpu;
      logic fpu_swap;
   } in_swap_t;

   typedef struct packed {
      logic frf;
      logic vis;
      logic fpu_lsu;
      logic keep;
   } rs2_src_t;

   typedef struct packed {
      logic rs2;
      logic rs1;
      logic frf;
      logic fsr;
   } out_sel_t;

   typedef struct packed {
      frf_shift_t frf_shift;
      logic       zero_low32;
      logic [1:0] sign;       // sign after abs or neg, {hi, lo}
      in_swap_t   in_swap;
      rs2_src_t   rs2_src;
      logic       new_rs1;
      out_sel_t   out_sel;
   } operand_ctl_t;

endpackage

// ==== src/thread_reg_bank.sv ====
`timescale 1ns/1ps

module thread_reg_bank #(
   parameter type payload_t = logic [31:0]
) (
   input  logic                 rclk,
   input  logic                 reset,
   input  ffu_pkg::thread_sel_t wr_en,
   input  payload_t             wr_data,
   input  ffu_pkg::thread_sel_t rd_sel,
   output payload_t             rd_data,
   output payload_t             wr_old
);

   payload_t regs [ffu_pkg::num_threads];  // one copy per thread

   ////////////////////
   // storage
   ////////////////////
   always_ff @(posedge rclk) begin
      for (int i = 0; i < ffu_pkg::num_threads; i++) begin
         if (reset) begin
            regs[i] <= '0;
         end else if (wr_en[i]) begin
            regs[i] <= wr_data;
         end
      end
   end

   ////////////////////
   // read ports
   ////////////////////
   // selects are one-hot, so the last match is the only match
   always_comb begin
      rd_data = '0;
      for (int i = 0; i < ffu_pkg::num_threads; i++) begin
         if (rd_sel[i]) rd_data = regs[i];
      end
   end

   // old value of the thread being written, for read-modify-write
   always_comb begin
      wr_old = '0;
      for (int i = 0; i < ffu_pkg::num_threads; i++) begin
         if (wr_en[i]) wr_old = regs[i];
      end
   end

   // merge logic upstream assumes a single thread written per cycle
   ap_wr_onehot0 : assert property (@(posedge rclk) disable iff (reset)
      $onehot0(wr_en))
      else $error("thread_reg_bank: wr_en names more than one thread");

   // control must always name a reader thread
   ap_rd_onehot : assert property (@(posedge rclk) disable iff (reset)
      $onehot(rd_sel))
      else $error("thread_reg_bank: rd_sel is not one-hot");

endmodule

// ==== src/ffu_operand_path.sv ====
`timescale 1ns/1ps

module ffu_operand_path (
   input  logic                  rclk,
   input  logic                  reset,
   input  ffu_pkg::operand_ctl_t ctl,
   input  ffu_pkg::data_t        frf_data,
   input  ffu_pkg::data_t        cpx_data,
   input  ffu_pkg::data_t        load_data,
   input  ffu_pkg::data_t        vis_rd_data,
   input  ffu_pkg::data_t        fsr_store,
   output ffu_pkg::data_t        load_data_q,
   output logic [1:0]            rs2_sign,
   output ffu_pkg::data_t        vis_rs1,
   output ffu_pkg::data_t        vis_rs2,
   output ffu_pkg::data_t        frf_wr_data,
   output ffu_pkg::data_t        lsu_data
);

   localparam int dw = ffu_pkg::data_w;
   localparam int hw = ffu_pkg::half_w;

   ffu_pkg::data_t cpx_q;        // fpu result, registered
   ffu_pkg::data_t shifted_frf;  // frf read after single alignment
   ffu_pkg::data_t new_frf;      // shifted, low word maybe zeroed
   ffu_pkg::data_t rs2_changed;  // new_frf with abs/neg sign bits
   ffu_pkg::data_t lsu_fpu;      // swap mux out
   ffu_pkg::data_t rs2_rd;       // holds rs2 and later rd
   ffu_pkg::data_t rs2_rd_next;
   ffu_pkg::data_t write_data;   // rd one more stage, toward frf
   ffu_pkg::data_t rs1;

   ////////////////////
   // input registers
   ////////////////////
   // load data is flopped here, its valid is flopped in the lsu
   always_ff @(posedge rclk) begin
      if (reset) begin
         cpx_q       <= '0;
         load_data_q <= '0;
      end else begin
         cpx_q       <= cpx_data;
         load_data_q <= load_data;
      end
   end

   always_comb begin
      lsu_fpu = ({dw{ctl.in_swap.lsu}}      & load_data_q)
              | ({dw{ctl.in_swap.lsu_swap}} & {load_data_q[hw-1:0], {hw{1'b0}}})
              | ({dw{ctl.in_swap.fpu}}      & cpx_q)
              | ({dw{ctl.in_swap.fpu_swap}} & {{hw{1'b0}}, cpx_q[dw-1:hw]});
   end

   ////////////////////
   // frf read path
   ////////////////////
   // singles may sit in either half; move them to where the consumer wants them
   always_comb begin
      shifted_frf = ({dw{ctl.frf_shift.none}}  & frf_data)
                  | ({dw{ctl.frf_shift.right}} & {{hw{1'b0}}, frf_data[dw-1:hw]})
                  | ({dw{ctl.frf_shift.left}}  & {frf_data[hw-1:0], {hw{1'b0}}});
   end

   assign new_frf = {shifted_frf[dw-1:hw], shifted_frf[hw-1:0] & {hw{~ctl.zero_low32}}};

   assign rs2_sign = {new_frf[dw-1], new_frf[hw-1]};  // to ctl for fabs/fneg

   assign rs2_changed = {ctl.sign[1], new_frf[dw-2:hw],
                         ctl.sign[0], new_frf[hw-2:0]};

   ////////////////////
   // rs2 / rd
   ////////////////////
   always_comb begin
      rs2_rd_next = ({dw{ctl.rs2_src.frf}}     & rs2_changed)
                  | ({dw{ctl.rs2_src.vis}}     & vis_rd_data)
                  | ({dw{ctl.rs2_src.fpu_lsu}} & lsu_fpu)
                  | ({dw{ctl.rs2_src.keep}}    & rs2_rd);
   end

   // write data trails rs2 by one stage for pipelined block loads
   always_ff @(posedge rclk) begin
      if (reset) begin
         rs2_rd     <= '0;
         write_data <= '0;
      end else begin
         rs2_rd     <= rs2_rd_next;
         write_data <= rs2_rd;
      end
   end

   assign vis_rs2     = rs2_rd;
   assign frf_wr_data = write_data;

   ////////////////////
   // rs1
   ////////////////////
   always_ff @(posedge rclk) begin
      if (reset) begin
         rs1 <= '0;
      end else if (ctl.new_rs1) begin
         rs1 <= new_frf;
      end
   end

   assign vis_rs1 = rs1;

   ////////////////////
   // data to lsu
   ////////////////////
   // stores can bypass straight from the shifted frf read
   always_comb begin
      lsu_data = ({dw{ctl.out_sel.rs2}} & rs2_rd)
               | ({dw{ctl.out_sel.rs1}} & rs1)
               | ({dw{ctl.out_sel.frf}} & shifted_frf)
               | ({dw{ctl.out_sel.fsr}} & fsr_store);
   end

   // the and-or muxes above give garbage on a bad select
   ap_shift_onehot : assert property (@(posedge rclk) disable iff (reset)
      $onehot(ctl.frf_shift))
      else $error("ffu_operand_path: frf_shift is not one-hot");

   ap_swap_onehot : assert property (@(posedge rclk) disable iff (reset)
      $onehot(ctl.in_swap))
      else $error("ffu_operand_path: in_swap is not one-hot");

   ap_rs2_onehot : assert property (@(posedge rclk) disable iff (reset)
      $onehot(ctl.rs2_src))
      else $error("ffu_operand_path: rs2_src is not one-hot");

   ap_out_onehot : assert property (@(posedge rclk) disable iff (reset)
      $onehot(ctl.out_sel))
      else $error("ffu_operand_path: out_sel is not one-hot");

endmodule

// ==== src/fsr_unit.sv ====
`timescale 1ns/1ps

module fsr_unit (
   input  logic                 rclk,
   input  logic                 reset,
   input  ffu_pkg::fsr_upd_t    upd,
   input  ffu_pkg::data_t       load_data_q,
   input  ffu_pkg::thread_sel_t fp_thr,
   output ffu_pkg::fsr_view_t   fsr,
   output ffu_pkg::data_t       fsr_store,
   output logic [7:0]           ld_fcc
);

   ffu_pkg::fsr_t        fsr_cur;    // thread picked by fp_thr
   ffu_pkg::fsr_t        fsr_old;    // thread being written
   ffu_pkg::fsr_t        ld_image;
   ffu_pkg::fsr_t        fpu_image;
   ffu_pkg::fsr_t        wr_image;
   ffu_pkg::thread_sel_t wr_en;

   ////////////////////
   // update images
   ////////////////////
   // ldfsr takes its fields from the store-image positions of the load word
   always_comb begin
      ld_image.fcc_hi = upd.fcc[7:2];
      ld_image.rnd    = load_data_q[ffu_pkg::fsr_st_rnd_lsb +: 2];
      ld_image.tem    = load_data_q[ffu_pkg::fsr_st_tem_lsb +: 5];
      ld_image.ftt    = fsr_old.ftt;        // a load never sets ftt
      ld_image.fcc0   = load_data_q[11:10];
      ld_image.aexc   = load_data_q[9:5];
      ld_image.cexc   = load_data_q[4:0];
   end

   always_comb begin
      fpu_image.fcc_hi = upd.fcc[7:2];
      fpu_image.rnd    = fsr_old.rnd;       // mode bits only change on a load
      fpu_image.tem    = fsr_old.tem;
      fpu_image.ftt    = upd.ftt;
      fpu_image.fcc0   = upd.fcc[1:0];
      fpu_image.aexc   = upd.exc[9:5];
      fpu_image.cexc   = upd.exc[4:0];
   end

   assign wr_en    = upd.ld_wr | upd.fpu_wr;
   assign wr_image = (|upd.ld_wr) ? ld_image : fpu_image;

   thread_reg_bank #(
      .payload_t (ffu_pkg::fsr_t)
   ) fsr_bank_inst (
      .rclk    (rclk),
      .reset   (reset),
      .wr_en   (wr_en),
      .wr_data (wr_image),
      .rd_sel  (fp_thr),
      .rd_data (fsr_cur),
      .wr_old  (fsr_old)
   );

   ////////////////////
   // outputs
   ////////////////////
   assign fsr.fcc  = {fsr_cur.fcc_hi, fsr_cur.fcc0};
   assign fsr.rnd  = fsr_cur.rnd;
   assign fsr.tem  = fsr_cur.tem;
   assign fsr.aexc = fsr_cur.aexc;
   assign fsr.cexc = fsr_cur.cexc;

   // stfsr image, reserved / ver / ns / qne read as zero
   always_comb begin
      fsr_store = '0;
      fsr_store[ffu_pkg::fsr_st_fcc_hi_lsb +: 6] = fsr_cur.fcc_hi;
      fsr_store[ffu_pkg::fsr_st_rnd_lsb +: 2]    = fsr_cur.rnd;
      fsr_store[ffu_pkg::fsr_st_tem_lsb +: 5]    = fsr_cur.tem;
      fsr_store[ffu_pkg::fsr_st_ftt_lsb +: 3]    = fsr_cur.ftt;
      fsr_store[11:0] = {fsr_cur.fcc0, fsr_cur.aexc, fsr_cur.cexc};
   end

   assign ld_fcc = {load_data_q[ffu_pkg::fsr_st_fcc_hi_lsb +: 6], load_data_q[11:10]};

   // a load and an fpu completion on the same cycle would lose one update
   ap_no_overlap : assert property (@(posedge rclk) disable iff (reset)
      (upd.ld_wr & upd.fpu_wr) == '0)
      else $error("fsr_unit: load and fpu write the fsr in the same cycle");

endmodule

// ==== src/ffu_dp_top.sv ====
`timescale 1ns/1ps

module ffu_dp_top (
   input  logic                  rclk,
   input  logic                  reset,
   input  ffu_pkg::operand_ctl_t operand_ctl,
   input  ffu_pkg::data_t        frf_data,
   input  ffu_pkg::data_t        cpx_data,
   input  ffu_pkg::data_t        load_data,
   input  ffu_pkg::data_t        vis_rd_data,
   input  ffu_pkg::fsr_upd_t     fsr_upd,
   input  ffu_pkg::thread_sel_t  fp_thr,
   input  ffu_pkg::thread_sel_t  gsr_wr,
   input  ffu_pkg::gsr_t         wsr_data,
   input  ffu_pkg::thread_sel_t  thr_e,
   output ffu_pkg::data_t        frf_wr_data,
   output ffu_pkg::data_t        lsu_data,
   output ffu_pkg::data_t        vis_rs1,
   output ffu_pkg::data_t        vis_rs2,
   output logic [1:0]            rs2_sign,
   output ffu_pkg::fsr_view_t    fsr,
   output logic [7:0]            ld_fcc,
   output ffu_pkg::gsr_t         gsr
);

   ffu_pkg::data_t load_data_q;  // registered load word, shared with fsr
   ffu_pkg::data_t fsr_store;    // stfsr image for the lsu mux

   ////////////////////
   // operands
   ////////////////////
   ffu_operand_path ffu_operand_path_inst (
      .rclk        (rclk),
      .reset       (reset),
      .ctl         (operand_ctl),
      .frf_data    (frf_data),
      .cpx_data    (cpx_data),
      .load_data   (load_data),
      .vis_rd_data (vis_rd_data),
      .fsr_store   (fsr_store),
      .load_data_q (load_data_q),
      .rs2_sign    (rs2_sign),
      .vis_rs1     (vis_rs1),
      .vis_rs2     (vis_rs2),
      .frf_wr_data (frf_wr_data),
      .lsu_data    (lsu_data)
   );

   ////////////////////
   // fsr
   ////////////////////
   fsr_unit fsr_unit_inst (
      .rclk        (rclk),
      .reset       (reset),
      .upd         (fsr_upd),
      .load_data_q (load_data_q),
      .fp_thr      (fp_thr),
      .fsr         (fsr),
      .fsr_store   (fsr_store),
      .ld_fcc      (ld_fcc)
   );

   ////////////////////
   // gsr
   ////////////////////
   // align and rnd live in ctl, only mask and scale are kept here
   thread_reg_bank #(
      .payload_t (ffu_pkg::gsr_t)
   ) gsr_bank_inst (
      .rclk    (rclk),
      .reset   (reset),
      .wr_en   (gsr_wr),
      .wr_data (wsr_data),
      .rd_sel  (thr_e),   // read for the thread in execute
      .rd_data (gsr),
      .wr_old  ()         // whole-register writes, no merge
   );

endmodule

// ==== include/ffu_tb_model.svh ====
`ifndef ffu_tb_model_svh
`define ffu_tb_model_svh

////////////////////
// model state
////////////////////
ffu_pkg::data_t ld_q_m;   // registered load word
ffu_pkg::data_t cpx_q_m;  // registered fpu result
ffu_pkg::data_t rs2_m;
ffu_pkg::data_t wdata_m;  // rs2 one stage later
ffu_pkg::data_t rs1_m;
ffu_pkg::fsr_t  fsr_m [ffu_pkg::num_threads];
ffu_pkg::gsr_t  gsr_m [ffu_pkg::num_threads];

function automatic int thread_of(ffu_pkg::thread_sel_t sel);
   for (int i = 0; i < ffu_pkg::num_threads; i++) begin
      if (sel[i]) return i;
   end
   return 0;
endfunction

function automatic ffu_pkg::data_t frf_aligned(ffu_pkg::frf_shift_t sh, ffu_pkg::data_t d);
   if (sh.right) return d >> 32;
   if (sh.left) return d << 32;
   return d;
endfunction

function automatic ffu_pkg::data_t frf_cleared(ffu_pkg::operand_ctl_t c, ffu_pkg::data_t d);
   ffu_pkg::data_t v;
   v = frf_aligned(c.frf_shift, d);
   if (c.zero_low32) v[31:0] = 32'h0;
   return v;
endfunction

function automatic ffu_pkg::data_t swapped_input(ffu_pkg::in_swap_t s);
   if (s.lsu_swap) return ld_q_m << 32;
   if (s.fpu) return cpx_q_m;
   if (s.fpu_swap) return cpx_q_m >> 32;
   return ld_q_m;
endfunction

// stfsr layout, gaps stay zero
function automatic ffu_pkg::data_t fsr_image(ffu_pkg::fsr_t f);
   ffu_pkg::data_t img;
   img = 64'(f.fcc_hi) << ffu_pkg::fsr_st_fcc_hi_lsb;
   img |= 64'(f.rnd) << ffu_pkg::fsr_st_rnd_lsb;
   img |= 64'(f.tem) << ffu_pkg::fsr_st_tem_lsb;
   img |= 64'(f.ftt) << ffu_pkg::fsr_st_ftt_lsb;
   img[11:0] = {f.fcc0, f.aexc, f.cexc};
   return img;
endfunction

function automatic ffu_pkg::fsr_view_t fsr_fields(ffu_pkg::fsr_t f);
   ffu_pkg::fsr_view_t v;
   v.fcc  = {f.fcc_hi, f.fcc0};
   v.rnd  = f.rnd;
   v.tem  = f.tem;
   v.aexc = f.aexc;
   v.cexc = f.cexc;
   return v;
endfunction

////////////////////
// edge update
////////////////////
task automatic update_model();
   ffu_pkg::data_t nf;
   int             t;
   if (reset) begin
      ld_q_m  = '0;
      cpx_q_m = '0;
      rs2_m   = '0;
      wdata_m = '0;
      rs1_m   = '0;
      for (int i = 0; i < ffu_pkg::num_threads; i++) begin
         fsr_m[i] = '0;
         gsr_m[i] = '0;
      end
   end else begin
      nf = frf_cleared(operand_ctl, frf_data);
      wdata_m = rs2_m;  // old rs2 moves on first
      if (operand_ctl.rs2_src.frf) begin
         rs2_m     = nf;
         rs2_m[63] = operand_ctl.sign[1];
         rs2_m[31] = operand_ctl.sign[0];
      end else if (operand_ctl.rs2_src.vis) begin
         rs2_m = vis_rd_data;
      end else if (operand_ctl.rs2_src.fpu_lsu) begin
         rs2_m = swapped_input(operand_ctl.in_swap);
      end
      if (operand_ctl.new_rs1) rs1_m = nf;
      t = thread_of(fsr_upd.ld_wr | fsr_upd.fpu_wr);
      if (|fsr_upd.ld_wr) begin
         fsr_m[t].fcc_hi = fsr_upd.fcc[7:2];
         fsr_m[t].rnd    = ld_q_m[31:30];
         fsr_m[t].tem    = ld_q_m[27:23];
         fsr_m[t].fcc0   = ld_q_m[11:10];
         fsr_m[t].aexc   = ld_q_m[9:5];
         fsr_m[t].cexc   = ld_q_m[4:0];
      end else if (|fsr_upd.fpu_wr) begin
         fsr_m[t].fcc_hi = fsr_upd.fcc[7:2];
         fsr_m[t].ftt    = fsr_upd.ftt;
         fsr_m[t].fcc0   = fsr_upd.fcc[1:0];
         {fsr_m[t].aexc, fsr_m[t].cexc} = fsr_upd.exc;
      end
      if (|gsr_wr) gsr_m[thread_of(gsr_wr)] = wsr_data;
      ld_q_m  = load_data;  // input regs last, rs2 used the old ones
      cpx_q_m = cpx_data;
   end
endtask

////////////////////
// compares
////////////////////
task automatic check_data(string name, ffu_pkg::data_t exp, ffu_pkg::data_t act);
   if (act !== exp) fail_value(name, $sformatf("%h", exp), $sformatf("%h", act));
endtask

task automatic check_rs2_sign(string name, logic [1:0] exp, logic [1:0] act);
   if (act !== exp) fail_value(name, $sformatf("%b", exp), $sformatf("%b", act));
endtask

task automatic check_fcc(string name, logic [7:0] exp, logic [7:0] act);
   if (act !== exp) fail_value(name, $sformatf("%h", exp), $sformatf("%h", act));
endtask

task automatic check_fsr(string name, ffu_pkg::fsr_view_t exp, ffu_pkg::fsr_view_t act);
   if (act !== exp) fail_value(name, $sformatf("%h", exp), $sformatf("%h", act));
endtask

task automatic check_gsr(string name, ffu_pkg::gsr_t exp, ffu_pkg::gsr_t act);
   if (act !== exp) fail_value(name, $sformatf("%h", exp), $sformatf("%h", act));
endtask

`endif

// ==== test/ffu_dp_tb.sv ====
`timescale 1ns/1ps

module ffu_dp_tb;

   logic                  rclk;
   logic                  reset;
   ffu_pkg::operand_ctl_t operand_ctl;
   ffu_pkg::data_t        frf_data;
   ffu_pkg::data_t        cpx_data;
   ffu_pkg::data_t        load_data;
   ffu_pkg::data_t        vis_rd_data;
   ffu_pkg::fsr_upd_t     fsr_upd;
   ffu_pkg::thread_sel_t  fp_thr;
   ffu_pkg::thread_sel_t  gsr_wr;
   ffu_pkg::gsr_t         wsr_data;
   ffu_pkg::thread_sel_t  thr_e;
   ffu_pkg::data_t        frf_wr_data;
   ffu_pkg::data_t        lsu_data;
   ffu_pkg::data_t        vis_rs1;
   ffu_pkg::data_t        vis_rs2;
   logic [1:0]            rs2_sign;
   ffu_pkg::fsr_view_t    fsr;
   logic [7:0]            ld_fcc;
   ffu_pkg::gsr_t         gsr;

   integer seed;
   int     wait_cnt;

   ffu_dp_top ffu_dp_top_inst (
      .rclk        (rclk),
      .reset       (reset),
      .operand_ctl (operand_ctl),
      .frf_data    (frf_data),
      .cpx_data    (cpx_data),
      .load_data   (load_data),
      .vis_rd_data (vis_rd_data),
      .fsr_upd     (fsr_upd),
      .fp_thr      (fp_thr),
      .gsr_wr      (gsr_wr),
      .wsr_data    (wsr_data),
      .thr_e       (thr_e),
      .frf_wr_data (frf_wr_data),
      .lsu_data    (lsu_data),
      .vis_rs1     (vis_rs1),
      .vis_rs2     (vis_rs2),
      .rs2_sign    (rs2_sign),
      .fsr         (fsr),
      .ld_fcc      (ld_fcc),
      .gsr         (gsr)
   );

   always #20 rclk = ~rclk;  // 40 ns period

   task automatic fail_run(string msg);
      $display("%s", msg);
      $display("Finished with errors");
      $fatal(1, "simulation stopped at the first error");
   endtask

   task automatic fail_value(string name, string exp, string act);
      fail_run($sformatf("Fail at %0t: %s expected %s, got %s", $time, name, exp, act));
   endtask

   `include "ffu_tb_model.svh"

   ////////////////////
   // stimulus
   ////////////////////
   function automatic int pick(int n);
      return int'($unsigned($random(seed)) % n);
   endfunction

   function automatic ffu_pkg::thread_sel_t one_thread();
      return ffu_pkg::thread_sel_t'(1) << pick(ffu_pkg::num_threads);
   endfunction

   function automatic ffu_pkg::data_t rand_word();
      return {$random(seed), $random(seed)};
   endfunction

   task automatic drive_random();
      ffu_pkg::operand_ctl_t c;
      int                    kind;
      c.frf_shift  = ffu_pkg::frf_shift_t'(3'b001 << pick(3));
      c.zero_low32 = 1'(pick(2));
      c.sign       = 2'(pick(4));
      c.in_swap    = ffu_pkg::in_swap_t'(4'b0001 << pick(4));
      c.rs2_src    = ffu_pkg::rs2_src_t'(4'b0001 << pick(4));
      c.new_rs1    = 1'(pick(2));
      c.out_sel    = ffu_pkg::out_sel_t'(4'b0001 << pick(4));
      operand_ctl  = c;
      frf_data     = rand_word();
      cpx_data     = rand_word();
      load_data    = rand_word();
      vis_rd_data  = rand_word();
      fsr_upd      = '0;
      fsr_upd.fcc  = 8'(pick(256));
      fsr_upd.exc  = 10'(pick(1024));
      fsr_upd.ftt  = 3'(pick(8));
      kind = pick(3);  // none, load or fpu
      if (kind == 1) fsr_upd.ld_wr = one_thread();
      else if (kind == 2) fsr_upd.fpu_wr = one_thread();
      fp_thr   = one_thread();
      gsr_wr   = (pick(2) != 0) ? one_thread() : '0;
      wsr_data = ffu_pkg::gsr_t'({$random(seed), 5'(pick(32))});
      thr_e    = one_thread();
   endtask

   // model follows the edge, inputs change 2 ns later, outputs sampled at the falling edge
   task automatic step();
      @(posedge rclk);
      update_model();
      #2;
      drive_random();
      #18;
   endtask

   task automatic check_outputs();
      ffu_pkg::data_t nf;
      ffu_pkg::data_t lsu_exp;
      nf = frf_cleared(operand_ctl, frf_data);
      check_rs2_sign("rs2_sign", {nf[63], nf[31]}, rs2_sign);
      check_data("vis_rs2", rs2_m, vis_rs2);
      check_data("frf_wr_data", wdata_m, frf_wr_data);
      check_data("vis_rs1", rs1_m, vis_rs1);
      if (operand_ctl.out_sel.rs2)
         lsu_exp = rs2_m;
      else if (operand_ctl.out_sel.rs1)
         lsu_exp = rs1_m;
      else if (operand_ctl.out_sel.frf)
         lsu_exp = frf_aligned(operand_ctl.frf_shift, frf_data);  // no low-word clear here
      else
         lsu_exp = fsr_image(fsr_m[thread_of(fp_thr)]);
      check_data("lsu_data", lsu_exp, lsu_data);
      check_fsr("fsr", fsr_fields(fsr_m[thread_of(fp_thr)]), fsr);
      check_fcc("ld_fcc", {ld_q_m[37:32], ld_q_m[11:10]}, ld_fcc);
      check_gsr("gsr", gsr_m[thread_of(thr_e)], gsr);
   endtask

   ////////////////////
   // run
   ////////////////////
   initial begin
      reset = 1'b1;
      repeat (2) @(posedge rclk);
      #2 reset = 1'b0;
   end

   initial begin
      seed = 18036;
      rclk = 1'b0;
      drive_random();
      wait_cnt = 0;
      while (reset !== 1'b0) begin
         if (wait_cnt == 20) fail_run("reset was still asserted after 20 cycles");
         step();
         wait_cnt++;
      end
      for (int i = 0; i < 2000; i++) begin
         check_outputs();
         step();
      end
      check_outputs();
      $display("Finished with no errors");
      $finish;
   end

endmodule

// ==== build.f ====
+incdir+include
src/ffu_pkg.sv
src/thread_reg_bank.sv
src/ffu_operand_path.sv
src/fsr_unit.sv
src/ffu_dp_top.sv
test/ffu_dp_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= ffu_dp_tb
FILELIST  ?= build.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)
